// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/icache_pkg.sv
      - verilog/icache_array_if.sv
      - verilog/bram_sdp.sv
      - verilog/icache_way.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/icache_mem_model.sv
      - testbench/icache_tb.sv

// ==== sources.f ====
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_array_if.sv
verilog/bram_sdp.sv
verilog/icache_way.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

// ==== testbench/icache_mem_model.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_mem_model (
    input  logic              clk,
    input  logic              rstn,
    input  logic [2:0]        i_latency,      // wait cycles for the next request
    input  logic              i_mem_rvalid,
    input  icache_pkg::addr_t i_mem_raddr,
    output logic              o_mem_rready,
    output icache_pkg::line_t o_mem_rdata
);

    localparam int WORDS = `ICACHE_LINE_W / `ICACHE_FETCH_W;

    logic       busy;
    logic [2:0] wait_cnt;

    // word n of the enclosing line carries its own byte address, complement on top
    function automatic icache_pkg::line_t line_at(input icache_pkg::addr_t addr);
        icache_pkg::line_t line;
        icache_pkg::addr_t word_addr;
        int                n;
        line = '0;
        for (n = 0; n < WORDS; n++) begin
            word_addr = {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
            word_addr = word_addr + 8 * n;
            line[n*`ICACHE_FETCH_W +: `ICACHE_FETCH_W] = {~word_addr, word_addr};
        end
        return line;
    endfunction

    initial begin
        o_mem_rready = 1'b0;
        o_mem_rdata  = '0;
        busy         = 1'b0;
        wait_cnt     = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rstn) begin
                o_mem_rready = 1'b0;
                busy         = 1'b0;
            end else if (o_mem_rready) begin
                o_mem_rready = 1'b0;          // one-cycle pulse
                busy         = 1'b0;
            end else if (i_mem_rvalid) begin
                if (!busy) begin
                    busy     = 1'b1;
                    wait_cnt = i_latency;     // latched once per request
                end
                if (wait_cnt == 0) begin
                    o_mem_rready = 1'b1;
                    o_mem_rdata  = line_at(i_mem_raddr);
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

endmodule

// ==== testbench/icache_tb.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_tb;

    localparam int          CLK_PERIOD = 8;
    localparam int          N_STREAM   = 200;
    localparam int          N_REQ      = 21 + N_STREAM;   // all reads of all tests
    localparam int          SETS       = 1 << `ICACHE_INDEX_W;
    localparam logic [31:0] PADDR_FLIP = 32'h8000_0000;   // physical is virtual with msb inverted

    logic               clk;
    logic               rstn;
    logic               i_rvalid;
    icache_pkg::addr_t  i_raddr;
    icache_pkg::addr_t  i_paddr;
    logic               i_uncache;
    logic               o_rready;
    icache_pkg::fetch_t o_rdata;
    logic               o_mem_rvalid;
    icache_pkg::addr_t  o_mem_raddr;
    logic               i_mem_rready;
    icache_pkg::line_t  i_mem_rdata;
    logic [2:0]         mem_latency;

    // software copy of tags, valid bits and lru
    logic               model_valid [SETS][2];
    icache_pkg::tag_t   model_tag   [SETS][2];
    logic               model_lru   [SETS];

    // expectations per read with the oldest first
    icache_pkg::fetch_t exp_data_q [$];
    logic               exp_mem_q  [$];
    icache_pkg::addr_t  exp_addr_q [$];
    logic               mem_seen;
    logic [31:0]        lfsr_q;

    icache_top i_icache_top (
        .clk          (clk),
        .rstn         (rstn),
        .i_rvalid     (i_rvalid),
        .i_raddr      (i_raddr),
        .i_paddr      (i_paddr),
        .i_uncache    (i_uncache),
        .o_rready     (o_rready),
        .o_rdata      (o_rdata),
        .o_mem_rvalid (o_mem_rvalid),
        .o_mem_raddr  (o_mem_raddr),
        .i_mem_rready (i_mem_rready),
        .i_mem_rdata  (i_mem_rdata)
    );

    icache_mem_model u_mem_model (
        .clk          (clk),
        .rstn         (rstn),
        .i_latency    (mem_latency),
        .i_mem_rvalid (o_mem_rvalid),
        .i_mem_raddr  (o_mem_raddr),
        .o_mem_rready (i_mem_rready),
        .o_mem_rdata  (i_mem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);                // one step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // expected fetch word for a physical address
    function automatic icache_pkg::fetch_t ref_word(input icache_pkg::addr_t paddr);
        icache_pkg::addr_t word_addr;
        word_addr = {paddr[`ICACHE_ADDR_W-1:3], 3'b000};
        return {~word_addr, word_addr};
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic clear_model();
        int s;
        for (s = 0; s < SETS; s++) begin
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
            model_lru[s]      = 1'b0;
        end
    endtask

    // updates the model and tells whether memory is asked and where
    task automatic predict(input icache_pkg::addr_t paddr, input logic unc,
                           output logic mem_due, output icache_pkg::addr_t mem_addr);
        icache_pkg::index_t idx;
        icache_pkg::tag_t   tag;
        logic               hit0;
        logic               hit1;
        logic               way;
        idx      = paddr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        tag      = paddr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        mem_due  = 1'b1;
        mem_addr = {paddr[`ICACHE_ADDR_W-1:3], 3'b000};
        if (!unc) begin
            hit0 = model_valid[idx][0] && (model_tag[idx][0] == tag);
            hit1 = model_valid[idx][1] && (model_tag[idx][1] == tag);
            if (hit0 || hit1) begin
                mem_due        = 1'b0;
                model_lru[idx] = hit0;                 // other way is now lru
            end else begin
                if (!model_valid[idx][0]) way = 1'b0;
                else if (!model_valid[idx][1]) way = 1'b1;
                else way = model_lru[idx];
                model_valid[idx][way] = 1'b1;
                model_tag[idx][way]   = tag;
                model_lru[idx]        = !way;
                mem_addr = {paddr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
            end
        end
    endtask

    // present one read and hold it until o_rready
    task automatic read_word(input icache_pkg::addr_t raddr, input logic unc);
        icache_pkg::addr_t paddr;
        icache_pkg::addr_t mem_addr;
        logic              mem_due;
        paddr = raddr ^ PADDR_FLIP;
        predict(paddr, unc, mem_due, mem_addr);
        exp_data_q.push_back(ref_word(paddr));
        exp_mem_q.push_back(mem_due);
        exp_addr_q.push_back(mem_addr);
        mem_latency = 3'(draw_bits(3));
        i_rvalid    = 1'b1;
        i_raddr     = raddr;
        i_paddr     = paddr;
        i_uncache   = unc;
        do begin
            @(posedge clk);
            #1;
        end while (!o_rready);
    endtask

    task automatic idle_cycle();
        i_rvalid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        i_rvalid = 1'b0;
        rstn     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        clear_model();
    endtask

    // 4 tags over 4 sets and now and then an uncached read
    task automatic run_stream();
        logic [1:0] tag_sel;
        logic [1:0] set_sel;
        logic [2:0] word;
        logic [2:0] byte_off;
        logic       unc;
        int         i;
        for (i = 0; i < N_STREAM; i++) begin
            tag_sel  = 2'(draw_bits(2));
            set_sel  = 2'(draw_bits(2));
            word     = 3'(draw_bits(3));
            byte_off = 3'(draw_bits(3));
            unc      = (draw_bits(4) == 4'hf);
            read_word({20'h00010 + 20'(tag_sel), set_sel, 4'h0, word, byte_off}, unc);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare at mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rstn) begin
            if (o_mem_rvalid && i_mem_rready) begin
                if (exp_mem_q.size() == 0) begin
                    stop_with_failure("memory request issued with no read outstanding");
                end else if (!exp_mem_q[0]) begin
                    stop_with_failure("memory request issued for a read that should hit");
                end else begin
                    check_value("memory address", o_mem_raddr, exp_addr_q[0]);
                    mem_seen = 1'b1;
                end
            end
            if (o_rready) begin
                if (exp_data_q.size() == 0) begin
                    stop_with_failure("cache answered with no read outstanding");
                end else begin
                    check_value("read data", o_rdata, exp_data_q[0]);
                    if (exp_mem_q[0] && !mem_seen) begin
                        stop_with_failure("read answered without the expected memory request");
                    end
                    void'(exp_data_q.pop_front());
                    void'(exp_mem_q.pop_front());
                    void'(exp_addr_q.pop_front());
                    mem_seen = 1'b0;
                end
            end
        end
    end

    initial begin
        #(N_REQ * 12 * CLK_PERIOD);
        stop_with_failure("timeout, the cache stopped answering read requests");
    end

    initial begin
        int w;
        clk         = 1'b0;
        rstn        = 1'b0;
        i_rvalid    = 1'b0;
        i_raddr     = '0;
        i_paddr     = '0;
        i_uncache   = 1'b0;
        mem_latency = '0;
        mem_seen    = 1'b0;
        lfsr_q      = 32'hbe8b;
        apply_reset();

        read_word(32'h0000_1238, 1'b0);               // cold miss in set 8
        for (w = 0; w < 7; w++) begin
            read_word(32'h0000_1200 + 32'(w * 8 + w), 1'b0);
        end
        idle_cycle();

        // three tags in set 5
        read_word(32'h0000_2140, 1'b0);
        read_word(32'h0000_3148, 1'b0);
        read_word(32'h0000_2150, 1'b0);
        read_word(32'h0000_4150, 1'b0);               // evicts 0x3xxx
        read_word(32'h0000_2158, 1'b0);
        read_word(32'h0000_3140, 1'b0);
        read_word(32'h0000_2148, 1'b0);
        idle_cycle();

        read_word(32'h0000_5a6c, 1'b1);               // uncached and never allocated
        read_word(32'h0000_5a40, 1'b0);
        read_word(32'h0000_5a6c, 1'b0);
        idle_cycle();

        run_stream();
        idle_cycle();

        read_word(32'h0000_1204, 1'b0);               // still cached from the start
        idle_cycle();
        apply_reset();
        read_word(32'h0000_1204, 1'b0);
        read_word(32'h0000_1210, 1'b0);
        idle_cycle();
        idle_cycle();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== verilog/bram_sdp.sv ====
`timescale 1ns/10ps

module bram_sdp #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 6
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] i_raddr,
    input  logic [ADDR_W-1:0] i_waddr,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic              i_we,
    output logic [DATA_W-1:0] o_rdata
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    // read-first, a write shows up for reads from the next cycle on
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];
    end

endmodule

// ==== verilog/icache_array_if.sv ====
`timescale 1ns/10ps

interface icache_array_if;

    // shared by both ways
    icache_pkg::index_t r_index;     // read set, data comes back next cycle
    icache_pkg::index_t w_index;     // refill set
    icache_pkg::tag_t   w_tag;
    icache_pkg::line_t  w_line;
    logic [1:0]         we;          // one bit per way

    // per-way read results, slot n belongs to way n
    logic               rd_valid [2];
    icache_pkg::tag_t   rd_tag   [2];
    icache_pkg::line_t  rd_line  [2];

    modport ctrl (
        output r_index, w_index, w_tag, w_line, we,
        input  rd_valid, rd_tag, rd_line
    );

    // write enable and read results are hooked up per slot in the top
    modport way (
        input  r_index, w_index, w_tag, w_line
    );

endinterface

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_ctrl (
    input  logic               clk,
    input  logic               rstn,
    // pipeline side
    input  logic               i_rvalid,
    input  icache_pkg::addr_t  i_raddr,     // virtual, indexes the arrays
    input  icache_pkg::addr_t  i_paddr,     // physical, supplies the tag
    input  logic               i_uncache,
    output logic               o_rready,
    output icache_pkg::fetch_t o_rdata,
    // memory side
    output logic               o_mem_rvalid,
    output icache_pkg::addr_t  o_mem_raddr,
    input  logic               i_mem_rready,
    input  icache_pkg::line_t  i_mem_rdata,
    // ways
    icache_array_if.ctrl       arr
);

    localparam int SETS     = 1 << `ICACHE_INDEX_W;
    localparam int WORD_LSB = 3;                      // 8 bytes per fetch word

    icache_pkg::icache_state_e state_q;
    icache_pkg::icache_state_e state_d;

    // request and return buffers
    icache_pkg::addr_t req_q;
    icache_pkg::addr_t paddr_q;
    logic              uncache_q;
    icache_pkg::line_t ret_buf;

    // lru_q[set] names the least recently used way of that set
    logic [SETS-1:0]   lru_q;

    icache_pkg::index_t req_index;
    icache_pkg::tag_t   req_tag;
    logic [1:0]         hit;
    logic               cache_hit;
    logic               hit_way;
    logic               victim;
    logic               take_req;
    icache_pkg::line_t  sel_line;
    logic [`ICACHE_OFFSET_W-WORD_LSB-1:0] word_sel;

    ////////////////////////////////////////////////////////////////////////////
    // request capture
    ////////////////////////////////////////////////////////////////////////////

    // a request is taken in IDLE, or in a hit cycle when the pipeline
    // already shows the next one
    assign take_req = i_rvalid &&
                      (state_q == icache_pkg::IDLE ||
                       (state_q == icache_pkg::LOOKUP && cache_hit));

    always_ff @(posedge clk) begin
        if (take_req) begin
            req_q     <= i_raddr;
            paddr_q   <= i_paddr;    // tag compare runs off this next cycle
            uncache_q <= i_uncache;
        end
    end

    // whole line from memory also for uncached reads
    always_ff @(posedge clk) begin
        if (o_mem_rvalid && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    assign req_index = req_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign req_tag   = paddr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign word_sel  = req_q[`ICACHE_OFFSET_W-1:WORD_LSB];

    ////////////////////////////////////////////////////////////////////////////
    // hit detection and victim choice
    ////////////////////////////////////////////////////////////////////////////

    assign hit[0]    = arr.rd_valid[0] && (arr.rd_tag[0] == req_tag);
    assign hit[1]    = arr.rd_valid[1] && (arr.rd_tag[1] == req_tag);
    assign cache_hit = (|hit) && !uncache_q;   // uncached always goes out
    assign hit_way   = !hit[0];

    // empty way first, way 0 before way 1, else the lru way
    always_comb begin
        if (!arr.rd_valid[0]) begin
            victim = 1'b0;
        end else if (!arr.rd_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[req_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (state_q == icache_pkg::LOOKUP && cache_hit) begin
            lru_q[req_index] <= !hit_way;     // hit way becomes mru
        end else if (|arr.we) begin
            lru_q[req_index] <= !victim;      // refilled way becomes mru
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (i_rvalid) state_d = icache_pkg::LOOKUP;
            end
            icache_pkg::LOOKUP: begin
                if (!cache_hit) begin
                    state_d = icache_pkg::MISS;
                end else if (!i_rvalid) begin
                    state_d = icache_pkg::IDLE;
                end
            end
            icache_pkg::MISS: begin
                if (i_mem_rready) state_d = icache_pkg::REFILL;
            end
            // line lands this cycle and the next request reads it from IDLE
            icache_pkg::REFILL: state_d = icache_pkg::IDLE;
            default:            state_d = icache_pkg::IDLE;
        endcase
    end

    assign o_rready = (state_q == icache_pkg::LOOKUP && cache_hit) ||
                      state_q == icache_pkg::REFILL;

    assign o_mem_rvalid = (state_q == icache_pkg::MISS);

    // line aligned for a fill, word aligned when uncached
    assign o_mem_raddr = uncache_q ?
                         {paddr_q[`ICACHE_ADDR_W-1:WORD_LSB], {WORD_LSB{1'b0}}} :
                         {paddr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                          {`ICACHE_OFFSET_W{1'b0}}};

    // fetch word from the hit way or from the return buffer
    assign sel_line = (state_q == icache_pkg::REFILL) ? ret_buf : arr.rd_line[hit_way];
    assign o_rdata  = sel_line[word_sel*`ICACHE_FETCH_W +: `ICACHE_FETCH_W];

    ////////////////////////////////////////////////////////////////////////////
    // array side
    ////////////////////////////////////////////////////////////////////////////

    // keep reading the pending set unless a new request is coming in
    assign arr.r_index = (state_q == icache_pkg::IDLE || take_req) ?
                         i_raddr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W] : req_index;
    assign arr.w_index = req_index;
    assign arr.w_tag   = req_tag;
    assign arr.w_line  = ret_buf;
    assign arr.we      = (state_q == icache_pkg::REFILL && !uncache_q) ?
                         (victim ? 2'b10 : 2'b01) : 2'b00;

    // memory request held steady under back-pressure
    a_mem_stable: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && !i_mem_rready |=> o_mem_rvalid && $stable(o_mem_raddr));

    // a refill only ever follows a miss in that set
    a_fill_after_miss: assert property (@(posedge clk) disable iff (!rstn)
        (|arr.we) |-> (hit == 2'b00));

    // a tag is never held by both ways of one set
    a_single_hit: assert property (@(posedge clk) disable iff (!rstn)
        state_q == icache_pkg::LOOKUP |-> $onehot0(hit));

endmodule

// ==== verilog/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// address as seen by the pipeline and the memory port
`define ICACHE_ADDR_W    32

// 64 sets, index at address bits 11:6
`define ICACHE_INDEX_W   6

// byte offset within a 64-byte line
`define ICACHE_OFFSET_W  6

// tag from address bits 31:12
`define ICACHE_TAG_W     20

// one full line, delivered in a single memory beat
`define ICACHE_LINE_W    512

// two instructions per read for the dual-issue front end
`define ICACHE_FETCH_W   64

`endif

// ==== verilog/icache_pkg.sv ====
`include "icache_defs.svh"

package icache_pkg;

    // byte address, virtual or physical
    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;

    // set number inside one way
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;     // physical tag
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;    // one cache line
    typedef logic [`ICACHE_FETCH_W-1:0] fetch_t;   // word handed to the pipeline

    // controller FSM
    typedef enum logic [1:0] {
        IDLE,      // waiting for a request
        LOOKUP,    // tags and lines are out of the RAMs, compare
        MISS,      // memory request outstanding
        REFILL     // line written back, data served from return buffer
    } icache_state_e;

endpackage

// ==== verilog/icache_top.sv ====
`timescale 1ns/10ps

module icache_top (
    input  logic               clk,
    input  logic               rstn,
    // pipeline
    input  logic               i_rvalid,
    input  icache_pkg::addr_t  i_raddr,
    input  icache_pkg::addr_t  i_paddr,
    input  logic               i_uncache,
    output logic               o_rready,
    output icache_pkg::fetch_t o_rdata,
    // memory
    output logic               o_mem_rvalid,
    output icache_pkg::addr_t  o_mem_raddr,
    input  logic               i_mem_rready,
    input  icache_pkg::line_t  i_mem_rdata
);

    icache_array_if arr_if ();

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_rvalid     (i_rvalid),
        .i_raddr      (i_raddr),
        .i_paddr      (i_paddr),
        .i_uncache    (i_uncache),
        .o_rready     (o_rready),
        .o_rdata      (o_rdata),
        .o_mem_rvalid (o_mem_rvalid),
        .o_mem_raddr  (o_mem_raddr),
        .i_mem_rready (i_mem_rready),
        .i_mem_rdata  (i_mem_rdata),
        .arr          (arr_if.ctrl)
    );

    // way n takes write bit n and drives read slot n
    for (genvar g = 0; g < 2; g++) begin : g_way
        icache_way u_way (
            .clk        (clk),
            .rstn       (rstn),
            .arr        (arr_if.way),
            .i_we       (arr_if.we[g]),
            .o_rd_valid (arr_if.rd_valid[g]),
            .o_rd_tag   (arr_if.rd_tag[g]),
            .o_rd_line  (arr_if.rd_line[g])
        );
    end

endmodule

// ==== verilog/icache_way.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_way (
    input  logic              clk,
    input  logic              rstn,
    icache_array_if.way       arr,
    input  logic              i_we,         // this way's refill strobe
    output logic              o_rd_valid,
    output icache_pkg::tag_t  o_rd_tag,
    output icache_pkg::line_t o_rd_line
);

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    logic [SETS-1:0] valid_q;

    bram_sdp #(
        .DATA_W (`ICACHE_TAG_W),
        .ADDR_W (`ICACHE_INDEX_W)
    ) u_tag_ram (
        .clk     (clk),
        .i_raddr (arr.r_index),
        .i_waddr (arr.w_index),
        .i_wdata (arr.w_tag),
        .i_we    (i_we),
        .o_rdata (o_rd_tag)
    );

    bram_sdp #(
        .DATA_W (`ICACHE_LINE_W),
        .ADDR_W (`ICACHE_INDEX_W)
    ) u_data_ram (
        .clk     (clk),
        .i_raddr (arr.r_index),
        .i_waddr (arr.w_index),
        .i_wdata (arr.w_line),
        .i_we    (i_we),
        .o_rdata (o_rd_line)
    );

    // valid bits live in flops so a reset empties the way at once
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q    <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            if (i_we) valid_q[arr.w_index] <= 1'b1;
            o_rd_valid <= valid_q[arr.r_index];   // old value, same as the RAMs
        end
    end

    // the controller comes out of reset idle, so nothing is written
    a_no_write_in_reset: assert property (@(posedge clk) !rstn |=> !i_we);

endmodule
